// ==== pn_pkg.sv ====
/*
 * Polish-notation evaluator shared types
 * Value, result and stored token types plus the operator codes
 * used by the token buffer, the operand stack and the evaluator
 */
`default_nettype none

package pn_pkg;

    // ========================================================================
    // Data widths
    // ========================================================================

    // Operands, intermediates and the internal result wrap at 16 bits
    typedef logic signed [15:0] value_t;

    // Result as driven on the top-level output
    typedef logic signed [31:0] result_t;

    // Stored token with the operator flag on top of a 3-bit code
    typedef logic [3:0] token_t;

    typedef logic [2:0] op_code_t;

    // ========================================================================
    // Operator codes
    // ========================================================================

    localparam op_code_t OP_ADD = 3'd0;
    localparam op_code_t OP_SUB = 3'd1;
    localparam op_code_t OP_MUL = 3'd2;
    // Absolute value of the sum
    localparam op_code_t OP_ABS = 3'd3;

    // Token field helpers
    function automatic logic token_is_op(token_t t);
        return t[3];
    endfunction

    function automatic op_code_t token_code(token_t t);
        return t[2:0];
    endfunction

endpackage

`default_nettype wire

// ==== token_buffer.sv ====
/*
 * Token buffer
 * Stores one burst of tokens, latches the mode on the first token and
 * walks the stored tokens in scan order once the burst has ended
 */
`default_nettype none

module token_buffer #(
    parameter int MAX_TOKENS = 16
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    input  wire                   mode,
    input  wire                   operator,
    input  wire pn_pkg::op_code_t in,
    input  wire                   advance,
    output logic                  loaded,
    output pn_pkg::token_t        token,
    output logic                  last,
    output logic                  postfix
);

    localparam int IDX_W = $clog2(MAX_TOKENS);

    pn_pkg::token_t   tokens [MAX_TOKENS];
    logic [IDX_W-1:0] wr_cnt;
    logic [IDX_W-1:0] last_wr;
    logic [IDX_W-1:0] rd_ptr;
    logic [IDX_W-1:0] end_idx;
    logic             in_valid_d;
    logic             burst_end;

    // First low in_valid after a burst
    assign burst_end = in_valid_d && !in_valid;
    assign last_wr   = wr_cnt - 1'b1;

    // ========================================================================
    // Write side
    // ========================================================================

    always_ff @(posedge clk) begin
        if (in_valid) begin
            tokens[wr_cnt] <= {operator, in};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt     <= '0;
            in_valid_d <= 1'b0;
            postfix    <= 1'b0;
        end else begin
            in_valid_d <= in_valid;
            if (in_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
                // Mode is only meaningful on the first token
                if (wr_cnt == '0) begin
                    postfix <= mode;
                end
            end else if (burst_end) begin
                wr_cnt <= '0;
            end
        end
    end

    // ========================================================================
    // Scan side
    // ========================================================================

    // Postfix scans upward from index 0, prefix downward from the last index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loaded  <= 1'b0;
            rd_ptr  <= '0;
            end_idx <= '0;
        end else begin
            loaded <= burst_end;
            if (burst_end) begin
                rd_ptr  <= postfix ? '0 : last_wr;
                end_idx <= postfix ? last_wr : '0;
            end else if (advance) begin
                rd_ptr <= postfix ? rd_ptr + 1'b1 : rd_ptr - 1'b1;
            end
        end
    end

    assign token = tokens[rd_ptr];
    assign last  = (rd_ptr == end_idx);

    // One slot stays unused so the counter never wraps inside a burst
    a_burst_length : assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> (wr_cnt < IDX_W'(MAX_TOKENS - 1))
    ) else $error("token burst longer than %0d tokens", MAX_TOKENS - 1);

endmodule

`default_nettype wire

// ==== operand_stack.sv ====
/*
 * Operand stack
 * Last-in first-out store of operand values with the top entry
 * always visible
 */
`default_nettype none

module operand_stack #(
    parameter int STACK_DEPTH = 8
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 push,
    input  wire                 pop,
    input  wire pn_pkg::value_t push_data,
    output pn_pkg::value_t      top
);

    localparam int ADDR_W = $clog2(STACK_DEPTH);
    // Pointer also has to hold the full count
    localparam int PTR_W  = $clog2(STACK_DEPTH + 1);

    pn_pkg::value_t    entries [STACK_DEPTH];
    logic [PTR_W-1:0]  sp;
    logic [ADDR_W-1:0] wr_idx;
    logic [ADDR_W-1:0] top_idx;
    logic              full;
    logic              empty;

    assign wr_idx  = ADDR_W'(sp);
    assign top_idx = ADDR_W'(sp - 1'b1);
    assign full    = (sp == PTR_W'(STACK_DEPTH));
    assign empty   = (sp == '0);

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_idx] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp <= '0;
        end else if (push) begin
            sp <= sp + 1'b1;
        end else if (pop) begin
            sp <= sp - 1'b1;
        end
    end

    // Entry just below the pointer
    assign top = entries[top_idx];

    // ========================================================================
    // Checks
    // ========================================================================

    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n) push |-> !full
    ) else $error("push on a full operand stack");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> !empty
    ) else $error("pop on an empty operand stack");

    a_push_pop_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n) !(push && pop)
    ) else $error("push and pop in the same cycle");

endmodule

`default_nettype wire

// ==== pn_evaluator.sv ====
/*
 * Polish-notation evaluator core
 * Scan FSM that pushes operands, pops two values per operator,
 * computes the 16-bit result and reports the final value once
 */
`default_nettype none

module pn_evaluator (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 loaded,
    input  wire pn_pkg::token_t token,
    input  wire                 last,
    input  wire                 postfix,
    input  wire pn_pkg::value_t top,
    output logic                advance,
    output logic                push,
    output logic                pop,
    output pn_pkg::value_t      push_data,
    output logic                out_valid,
    output pn_pkg::result_t     out
);

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        PUSH_OPERAND,
        POP_FIRST,
        POP_SECOND,
        COMPUTE,
        PUSH_RESULT,
        REPORT
    } eval_state_t;

    eval_state_t      state;
    eval_state_t      state_next;

    logic             is_op;
    pn_pkg::op_code_t code;

    // First and second popped values
    pn_pkg::value_t   opnd_a;
    pn_pkg::value_t   opnd_b;
    pn_pkg::value_t   sum;
    pn_pkg::value_t   alu_out;
    pn_pkg::value_t   result_q;

    assign is_op = pn_pkg::token_is_op(token);
    assign code  = pn_pkg::token_code(token);

    // ========================================================================
    // Scan FSM
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (loaded) begin
                    state_next = DECODE;
                end
            end
            DECODE: begin
                state_next = is_op ? POP_FIRST : PUSH_OPERAND;
            end
            PUSH_OPERAND: begin
                state_next = DECODE;
            end
            POP_FIRST: begin
                state_next = POP_SECOND;
            end
            POP_SECOND: begin
                state_next = COMPUTE;
            end
            COMPUTE: begin
                // The last token in scan order is always an operator
                state_next = last ? REPORT : PUSH_RESULT;
            end
            PUSH_RESULT: begin
                state_next = DECODE;
            end
            REPORT: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Pointer moves once the token under it is fully consumed
    assign advance = (state == PUSH_OPERAND) || (state == COMPUTE && !last);
    assign push    = (state == PUSH_OPERAND) || (state == PUSH_RESULT);
    assign pop     = (state == POP_FIRST) || (state == POP_SECOND);

    // Operands are pushed zero-extended
    assign push_data = (state == PUSH_RESULT) ? result_q : pn_pkg::value_t'(code);

    // ========================================================================
    // Operand registers and arithmetic
    // ========================================================================

    // Top is sampled as the pop takes effect
    always_ff @(posedge clk) begin
        if (state == POP_FIRST) begin
            opnd_a <= top;
        end
        if (state == POP_SECOND) begin
            opnd_b <= top;
        end
        if (state == COMPUTE) begin
            result_q <= alu_out;
        end
    end

    assign sum = opnd_a + opnd_b;

    // Postfix pops the right operand first, prefix pops the left one first
    always_comb begin
        unique case (code)
            pn_pkg::OP_ADD: alu_out = sum;
            pn_pkg::OP_SUB: alu_out = postfix ? opnd_b - opnd_a : opnd_a - opnd_b;
            pn_pkg::OP_MUL: alu_out = opnd_a * opnd_b;
            pn_pkg::OP_ABS: alu_out = (sum < 0) ? -sum : sum;
            default:        alu_out = sum;
        endcase
    end

    // ========================================================================
    // Result output
    // ========================================================================

    assign out_valid = (state == REPORT);
    assign out       = out_valid ? pn_pkg::result_t'(result_q) : '0;

    a_op_code_supported : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == DECODE && is_op) |-> (code <= pn_pkg::OP_ABS)
    ) else $error("unsupported operator code %0d", code);

    // A new burst may only finish after the previous result was reported
    a_loaded_when_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        loaded |-> (state == IDLE)
    ) else $error("new expression loaded while evaluation still running");

endmodule

`default_nettype wire

// ==== pn_top.sv ====
/*
 * Polish-notation evaluator top level
 * Token buffer and operand stack side by side, combined by the
 * evaluator FSM into one result pulse per expression
 */
`default_nettype none

module pn_top #(
    parameter int MAX_TOKENS  = 16,
    parameter int STACK_DEPTH = 8
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   mode,
    input  wire                   operator,
    input  wire pn_pkg::op_code_t in,
    input  wire                   in_valid,
    output logic                  out_valid,
    output pn_pkg::result_t       out
);

    logic           loaded;
    pn_pkg::token_t token;
    logic           last;
    logic           postfix;
    logic           advance;
    logic           push;
    logic           pop;
    pn_pkg::value_t push_data;
    pn_pkg::value_t stack_top;

    token_buffer #(
        .MAX_TOKENS (MAX_TOKENS)
    ) u_token_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .mode     (mode),
        .operator (operator),
        .in       (in),
        .advance  (advance),
        .loaded   (loaded),
        .token    (token),
        .last     (last),
        .postfix  (postfix)
    );

    operand_stack #(
        .STACK_DEPTH (STACK_DEPTH)
    ) u_operand_stack (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .pop       (pop),
        .push_data (push_data),
        .top       (stack_top)
    );

    pn_evaluator u_pn_evaluator (
        .clk       (clk),
        .rst_n     (rst_n),
        .loaded    (loaded),
        .token     (token),
        .last      (last),
        .postfix   (postfix),
        .top       (stack_top),
        .advance   (advance),
        .push      (push),
        .pop       (pop),
        .push_data (push_data),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

`default_nettype wire

// ==== tb_pn_model.svh ====
/*
 * Reference model for the Polish-notation evaluator testbench
 * Galois LFSR, random expression tree builder, token emitter
 * and a tree evaluator that follows the written operand order
 */
`ifndef TB_PN_MODEL_SVH
`define TB_PN_MODEL_SVH

// ========================================================================
// Random bits
// ========================================================================

logic [31:0] lfsr_state = 32'h14ced73a;

// One Galois step per bit taken, right shift form
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// ========================================================================
// Expression tree and token list
// ========================================================================

logic        node_op    [16];
logic [2:0]  node_code  [16];
int          node_left  [16];
int          node_right [16];
logic [15:0] node_val   [16];
int          node_cnt;

logic        tok_op   [16];
logic [2:0]  tok_code [16];
int          tok_cnt;

// Left and right are in written order, arithmetic wraps at 16 bits
function automatic logic [15:0] ref_apply(logic [2:0] code, logic [15:0] a,
                                          logic [15:0] b);
    logic [15:0] s;
    s = a + b;
    case (code)
        3'd0: return s;
        3'd1: return a - b;
        3'd2: return a * b;
        // Negating -32768 wraps back to itself
        default: return s[15] ? (~s + 16'd1) : s;
    endcase
endfunction

task automatic add_token(input logic op, input logic [2:0] code);
    tok_op[tok_cnt]   = op;
    tok_code[tok_cnt] = code;
    tok_cnt++;
endtask

// Nodes are created in postfix order, the last one is the root
task automatic build_expr(input logic mul_only);
    int work [16];
    int depth;
    int ops_left;
    int opnds_left;
    int n;
    node_cnt = 0;
    depth    = 0;
    ops_left = int'(rand_bits(3));
    if (ops_left == 0 || mul_only) begin
        ops_left = 7;
    end
    opnds_left = ops_left + 1;
    while (ops_left + opnds_left > 0) begin
        n = node_cnt;
        node_cnt++;
        if (opnds_left > 0 && (depth < 2 || rand_bits(1) == 1)) begin
            node_op[n]   = 1'b0;
            node_code[n] = mul_only ? 3'(4 + rand_bits(2)) : 3'(rand_bits(3));
            node_val[n]  = {13'd0, node_code[n]};
            opnds_left--;
        end else begin
            node_op[n]    = 1'b1;
            node_code[n]  = mul_only ? 3'd2 : 3'(rand_bits(2));
            node_right[n] = work[depth-1];
            node_left[n]  = work[depth-2];
            depth         = depth - 2;
            node_val[n]   = ref_apply(node_code[n], node_val[node_left[n]],
                                      node_val[node_right[n]]);
            ops_left--;
        end
        work[depth] = n;
        depth++;
    end
endtask

// Prefix order comes from a depth-first walk with an explicit stack
task automatic emit_tokens(input logic postfix);
    int walk [16];
    int sp;
    int n;
    tok_cnt = 0;
    if (postfix) begin
        for (int i = 0; i < node_cnt; i++) begin
            add_token(node_op[i], node_code[i]);
        end
    end else begin
        walk[0] = node_cnt - 1;
        sp      = 1;
        while (sp > 0) begin
            sp--;
            n = walk[sp];
            add_token(node_op[n], node_code[n]);
            if (node_op[n]) begin
                walk[sp]   = node_right[n];
                walk[sp+1] = node_left[n];
                sp         = sp + 2;
            end
        end
    end
endtask

function automatic pn_pkg::result_t expected_result();
    logic [15:0] v;
    v = node_val[node_cnt-1];
    return {{16{v[15]}}, v};
endfunction

`endif

// ==== tb_pn.sv ====
/*
 * Testbench for the Polish-notation evaluator
 * Directed and random expressions in prefix and postfix form,
 * results checked by assertions against a reference queue
 */
`default_nettype none

module tb_pn;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 400;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             mode;
    logic             operator;
    pn_pkg::op_code_t in;
    logic             out_valid;
    pn_pkg::result_t  out;

    pn_pkg::result_t  exp_q [$];
    pn_pkg::result_t  exp_head;
    logic             exp_avail;
    int               sent;
    int               pulses;

    `include "tb_pn_model.svh"

    pn_top #(
        .MAX_TOKENS  (16),
        .STACK_DEPTH (8)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mode      (mode),
        .operator  (operator),
        .in        (in),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .out       (out)
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // ========================================================================
    // Result checks
    // ========================================================================

    a_out_zero_when_idle : assert property (
        @(posedge clk) disable iff (!rst_n) !out_valid |-> (out == '0)
    ) else stop_on_error($sformatf("ERR t=%0t out expected %h actual %h",
                                   $time, 32'h0, $sampled(out)));

    a_result_expected : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> exp_avail
    ) else stop_on_error("out_valid pulsed with no expression pending");

    a_result_value : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> (out == exp_head)
    ) else stop_on_error($sformatf("ERR t=%0t out expected %h actual %h",
                                   $time, $sampled(exp_head), $sampled(out)));

    a_single_pulse : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid
    ) else stop_on_error("out_valid stayed high for more than one cycle");

    // A one-cycle pulse is seen on exactly one falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid === 1'b1) begin
            pulses++;
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Result retires on the falling edge after the checking edge
    task automatic wait_result();
        int cycles;
        cycles = 0;
        while (out_valid !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (out_valid !== 1'b1) begin
            stop_on_error($sformatf("no out_valid within %0d cycles", TIMEOUT_CYCLES));
        end else begin
            @(negedge clk);
            void'(exp_q.pop_front());
            exp_avail = (exp_q.size() > 0);
            if (exp_avail) begin
                exp_head = exp_q[0];
            end
        end
    endtask

    // Later tokens carry the opposite mode, only the first one counts
    task automatic send_expr(input logic postfix, input pn_pkg::result_t expected);
        exp_q.push_back(expected);
        exp_head  = exp_q[0];
        exp_avail = 1'b1;
        sent++;
        for (int i = 0; i < tok_cnt; i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            mode     = (i == 0) ? postfix : ~postfix;
            operator = tok_op[i];
            in       = tok_code[i];
        end
        @(negedge clk);
        in_valid = 1'b0;
        operator = 1'b0;
        in       = '0;
        wait_result();
    endtask

    // One nibble per token, first token in the top nibble
    task automatic send_packed(input logic postfix, input logic [63:0] bits,
                               input int count, input int expected);
        tok_cnt = 0;
        for (int i = count - 1; i >= 0; i--) begin
            add_token(bits[4*i+3], bits[4*i +: 3]);
        end
        send_expr(postfix, pn_pkg::result_t'(expected));
    endtask

    initial begin
        logic pf;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        mode      = 1'b0;
        operator  = 1'b0;
        in        = '0;
        exp_head  = '0;
        exp_avail = 1'b0;
        sent      = 0;
        pulses    = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        // Postfix, one per operator
        send_packed(1'b1, 64'h358, 3, 8);
        send_packed(1'b1, 64'h269, 3, -4);
        send_packed(1'b1, 64'h629, 3, 4);
        send_packed(1'b1, 64'h37A, 3, 21);
        send_packed(1'b1, 64'h34B, 3, 7);
        send_packed(1'b1, 64'h0792B, 5, 5);
        send_packed(1'b1, 64'h123A9, 5, -5);

        // Same expressions written in prefix
        send_packed(1'b0, 64'h835, 3, 8);
        send_packed(1'b0, 64'h926, 3, -4);
        send_packed(1'b0, 64'h962, 3, 4);
        send_packed(1'b0, 64'hA37, 3, 21);
        send_packed(1'b0, 64'hB34, 3, 7);
        send_packed(1'b0, 64'hB9072, 5, 5);
        send_packed(1'b0, 64'h91A23, 5, -5);

        // Random trees, the last ones are multiply chains that wrap
        for (int n = 0; n < 80; n++) begin
            pf = 1'(rand_bits(1));
            build_expr(n >= 68);
            emit_tokens(pf);
            send_expr(pf, expected_result());
        end

        if (pulses != sent) begin
            stop_on_error($sformatf("%0d expressions sent but %0d results seen",
                                    sent, pulses));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
pn_pkg.sv
token_buffer.sv
operand_stack.sv
pn_evaluator.sv
pn_top.sv
tb_pn.sv

// ==== Bender.yml ====
package:
  name: pn_eval

sources:
  - pn_pkg.sv
  - token_buffer.sv
  - operand_stack.sv
  - pn_evaluator.sv
  - pn_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pn.sv
